//--- common/oled_cmd_pkg.sv
package oled_cmd_pkg;

    typedef logic [7:0] cmd_byte_t;

    typedef enum logic [1:0]
    {
        ST_RESET,
        ST_INIT,
        ST_PIXELS
    } oled_state_t;

    localparam int INIT_LEN = 12;

    // panel setup list, sent with dc low
    function automatic cmd_byte_t init_byte(input logic [3:0] idx);
        case (idx)
            4'd0:    return 8'hAE;   // display off
            4'd1:    return 8'hA0;   // remap
            4'd2:    return 8'h72;   // 65k colour, x flip
            4'd3:    return 8'hA1;   // start line
            4'd4:    return 8'hA2;   // display offset
            4'd5:    return 8'hA4;   // normal mode
            4'd6:    return 8'hA8;   // multiplex ratio
            4'd7:    return 8'hAD;   // master config
            4'd8:    return 8'h81;   // contrast
            4'd9:    return 8'h15;   // column window
            4'd10:   return 8'h75;   // row window
            4'd11:   return 8'hAF;   // display on
            default: return 8'hE3;   // nop
        endcase
    endfunction

endpackage

//--- common/oled_params.svh
`ifndef OLED_PARAMS_SVH
`define OLED_PARAMS_SVH

// panel geometry
`define OLED_WIDTH          96
`define OLED_HEIGHT         64

// displayed word, 32 hex digits
`define HEX_DATA_BITS       128

// glyph cell in pixels
`define GLYPH_W             6
`define GLYPH_H             8

// pixel buffer entries, also the initial credit count
`define PIXEL_FIFO_DEPTH    8

// panel reset pulse length in clk cycles
`define RESET_HOLD_CYCLES   16

// RGB565 colours
`define FG_COLOR            16'hFFE0
`define BG_COLOR            16'h0010

`endif

//--- common/pixel_pkg.sv
package pixel_pkg;

    typedef logic [6:0]  pixel_x_t;   // column 0..95
    typedef logic [5:0]  pixel_y_t;   // row 0..63
    typedef logic [15:0] color_t;     // RGB565
    typedef logic [3:0]  nibble_t;
    typedef logic [5:0]  glyph_row_t; // bit 5 is leftmost

    // 5x7 hex font in a 6x8 cell, right column and bottom row blank
    function automatic glyph_row_t hex_glyph_row(input nibble_t n, input logic [2:0] row);
        logic [34:0] g;   // 7 rows of 5 bits, top row first
        case (n)
            4'h0: g = 35'b01110_10001_10011_10101_11001_10001_01110;
            4'h1: g = 35'b00100_01100_00100_00100_00100_00100_01110;
            4'h2: g = 35'b01110_10001_00001_00010_00100_01000_11111;
            4'h3: g = 35'b11111_00010_00100_00010_00001_10001_01110;
            4'h4: g = 35'b00010_00110_01010_10010_11111_00010_00010;
            4'h5: g = 35'b11111_10000_11110_00001_00001_10001_01110;
            4'h6: g = 35'b00110_01000_10000_11110_10001_10001_01110;
            4'h7: g = 35'b11111_00001_00010_00100_01000_01000_01000;
            4'h8: g = 35'b01110_10001_10001_01110_10001_10001_01110;
            4'h9: g = 35'b01110_10001_10001_01111_00001_00010_01100;
            4'hA: g = 35'b01110_10001_10001_11111_10001_10001_10001;
            4'hB: g = 35'b11110_10001_10001_11110_10001_10001_11110;
            4'hC: g = 35'b01110_10001_10000_10000_10000_10001_01110;
            4'hD: g = 35'b11100_10010_10001_10001_10001_10010_11100;
            4'hE: g = 35'b11111_10000_10000_11110_10000_10000_11111;
            default: g = 35'b11111_10000_10000_11110_10000_10000_10000;
        endcase
        if (row == 3'd7)
        begin
            return '0;   // spacing row
        end
        return {g[(6 - row) * 5 +: 5], 1'b0};
    endfunction

endpackage

//--- dv/hex_oled_tb.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module hex_oled_tb
    import pixel_pkg::*;
    import oled_cmd_pkg::*;
();

    localparam int FRAME_PIXELS = `OLED_WIDTH * `OLED_HEIGHT;
    localparam int TEXT_PIXELS  = 2 * `GLYPH_H * `OLED_WIDTH;   // text rows 0 and 1
    localparam int CHANGE_IDX   = 800;                  // inside text row 1 of frame 0
    localparam int STALL_IDX    = FRAME_PIXELS + 300;   // inside the glyphs of frame 1
    localparam int END_IDX      = 2 * FRAME_PIXELS + TEXT_PIXELS;
    localparam int STALL_HOLD   = 200;
    localparam int IDLE_QUIET   = 40;   // longer than a byte plus its gap
    localparam int IDLE_LIMIT   = (`PIXEL_FIFO_DEPTH + 2) * 2 * 17 + 100;
    localparam int WATCH_CYCLES =
        2 * (3 * FRAME_PIXELS * 32 + 3 + `RESET_HOLD_CYCLES + INIT_LEN * 16);
    localparam int MAX_PRINTS   = 20;

    localparam int T_RESET    = 0;
    localparam int T_INIT     = 1;
    localparam int T_CONTENT  = 2;
    localparam int T_SAMPLING = 3;
    localparam int T_STALL    = 4;
    localparam int T_PROTO    = 5;
    localparam int NUM_TESTS  = 6;

    logic                      clk;
    logic                      reset;
    logic                      en;
    logic [`HEX_DATA_BITS-1:0] data;
    logic                      oled_csn;
    logic                      oled_clk;
    logic                      oled_mosi;
    logic                      oled_dc;
    logic                      oled_resn;

    logic [`HEX_DATA_BITS-1:0] word_for_frame [3];
    int test_errors [NUM_TESTS] = '{default: 0};
    int pass_count    = 0;
    int fail_count    = 0;
    int printed       = 0;
    int checked_count = 0;
    int resume_idx    = 32'h7fffffff;   // first pixel after the stall

    hex_oled_top UUT
    (
        .clk       (clk),
        .reset     (reset),
        .data      (data),
        .en        (en),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    spi_oled_monitor mon
    (
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc)
    );

    function automatic string test_name(input int t);
        case (t)
            T_RESET:    return "reset_state";
            T_INIT:     return "init_sequence";
            T_CONTENT:  return "frame_content";
            T_SAMPLING: return "frame_sampling";
            T_STALL:    return "stall";
            default:    return "protocol";
        endcase
    endfunction

    function automatic logic [`HEX_DATA_BITS-1:0] random_word();
        logic [`HEX_DATA_BITS-1:0] w;
        w = {$urandom, $urandom, $urandom, $urandom};
        return w;
    endfunction

    // expected colour of one raster position for a given word
    function automatic color_t ref_color(input logic [`HEX_DATA_BITS-1:0] word, input int pos);
        int         x;
        int         y;
        int         digit;
        nibble_t    nib;
        glyph_row_t row_bits;
        x = pos % `OLED_WIDTH;
        y = pos / `OLED_WIDTH;
        if (y >= 2 * `GLYPH_H)
        begin
            return `BG_COLOR;
        end
        digit    = (y / `GLYPH_H) * (`OLED_WIDTH / `GLYPH_W) + x / `GLYPH_W;
        nib      = nibble_t'(word >> (`HEX_DATA_BITS - 4 - 4 * digit));   // digit 0 on top
        row_bits = hex_glyph_row(nib, 3'(y % `GLYPH_H));
        return row_bits[5 - x % `GLYPH_W] ? `FG_COLOR : `BG_COLOR;
    endfunction

    task automatic report_value(input int t, input logic [31:0] expected,
                                input logic [31:0] actual);
        test_errors[t]++;
        $display("error %s expected %0h actual %0h", test_name(t), expected, actual);
    endtask

    task automatic report_failure(input int t, input string msg);
        test_errors[t]++;
        $display("%s: %s", test_name(t), msg);
    endtask

    task automatic report_pixel(input int t, input color_t expected, input color_t actual,
                                input int pos);
        test_errors[t]++;
        if (printed < MAX_PRINTS)   // keep a broken frame from flooding the log
        begin
            printed++;
            $display("error %s expected %h actual %h at x %0d y %0d", test_name(t),
                     expected, actual, pos % `OLED_WIDTH, pos / `OLED_WIDTH);
        end
    endtask

    task automatic finish_test(input int t);
        if (test_errors[t] == 0)
        begin
            pass_count++;
            $display("test %s passed", test_name(t));
        end
        else
        begin
            fail_count++;
            $display("test %s failed with %0d errors", test_name(t), test_errors[t]);
        end
    endtask

    task automatic check_pixel(input int idx);
        int     pos;
        int     t;
        color_t expected;
        color_t actual;
        pos      = idx % FRAME_PIXELS;
        expected = ref_color(word_for_frame[idx / FRAME_PIXELS], pos);
        actual   = mon.pix_log[idx];
        if (idx < FRAME_PIXELS)
        begin
            t = T_CONTENT;
        end
        else if (idx < 2 * FRAME_PIXELS)
        begin
            t = T_SAMPLING;
        end
        else
        begin
            t = T_STALL;
        end
        assert (actual == expected)
            else
            begin
                report_pixel(t, expected, actual, pos);
                if (t == T_CONTENT && idx >= CHANGE_IDX)
                begin
                    test_errors[T_SAMPLING]++;   // rest of frame 0 must keep the old word
                end
                if (t == T_SAMPLING && idx >= resume_idx)
                begin
                    test_errors[T_STALL]++;
                end
            end
    endtask

    task automatic check_reset_state();
        int cycles;
        cycles = 0;
        assert (!UUT.push && !UUT.pop && !UUT.credit && !oled_dc)
            else report_failure(T_RESET, "push, pop, credit or dc not low after reset");
        while (!oled_resn && cycles <= 4 * `RESET_HOLD_CYCLES)
        begin
            assert (oled_csn && !oled_clk)
                else report_failure(T_RESET, "SPI pins active during panel reset");
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        assert (cycles == `RESET_HOLD_CYCLES)
            else report_value(T_RESET, `RESET_HOLD_CYCLES, cycles);
    endtask

    task automatic check_init_sequence();
        while (mon.cmd_count < INIT_LEN)
        begin
            @(mon.byte_done);
        end
        assert (!mon.data_before_init)
            else report_failure(T_INIT, "data byte sent before the init list finished");
        for (int i = 0; i < INIT_LEN; i++)
        begin
            assert (mon.cmd_log[i] == init_byte(4'(i)))
                else report_value(T_INIT, init_byte(4'(i)), mon.cmd_log[i]);
        end
    endtask

    task automatic run_stall();
        int drained_from;
        int quiet;
        int cycles;
        int edges_before;
        while (mon.pix_count < STALL_IDX)
        begin
            @(mon.pixel_done);
        end
        @(negedge clk);   // next pixel not popped yet
        en           = 1'b0;
        drained_from = mon.pix_count;
        quiet        = 0;
        cycles       = 0;
        while (quiet < IDLE_QUIET && cycles < IDLE_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            quiet = (oled_csn && !oled_clk) ? quiet + 1 : 0;
        end
        assert (quiet >= IDLE_QUIET)
            else report_failure(T_STALL, "panel pins did not go idle with en low");
        assert (mon.pix_count - drained_from <= `PIXEL_FIFO_DEPTH)
            else report_value(T_STALL, `PIXEL_FIFO_DEPTH, mon.pix_count - drained_from);
        assert (!mon.hi_valid)
            else report_failure(T_STALL, "stream stopped between the two bytes of a pixel");
        edges_before = mon.clk_edges;
        repeat (STALL_HOLD)
        begin
            @(negedge clk);
            assert (oled_csn)
                else report_failure(T_STALL, "csn went low while stalled");
        end
        assert (mon.clk_edges == edges_before)
            else report_value(T_STALL, edges_before, mon.clk_edges);
        resume_idx = mon.pix_count;
        en         = 1'b1;
    endtask

    task automatic check_protocol_end();
        assert (mon.cmd_count == INIT_LEN)
            else report_value(T_PROTO, INIT_LEN, mon.cmd_count);
        assert (mon.frame_errors == 0)
            else report_value(T_PROTO, 0, mon.frame_errors);
    endtask

    // SPI clock stays low whenever the panel is deselected
    a_clk_quiet: assert property (@(posedge clk) disable iff (reset)
        oled_csn |-> !oled_clk)
        else report_failure(T_PROTO, "oled_clk high while csn is high");

    a_dc_stable: assert property (@(posedge clk) disable iff (reset)
        (!oled_csn && !$past(oled_csn)) |-> $stable(oled_dc))
        else report_failure(T_PROTO, "oled_dc changed during a byte");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        UUT.hex_decoder_inst.credits <= `PIXEL_FIFO_DEPTH)
        else report_failure(T_PROTO, "decoder holds more credits than buffer entries");

    a_push_credit: assert property (@(posedge clk) disable iff (reset)
        UUT.push |-> $past(UUT.hex_decoder_inst.credits) != 0)
        else report_failure(T_PROTO, "decoder pushed without a credit");

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        UUT.push |-> UUT.pixel_fifo_inst.count != `PIXEL_FIFO_DEPTH)
        else report_failure(T_PROTO, "pixel buffer pushed while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        UUT.pop |-> UUT.pix_avail)
        else report_failure(T_PROTO, "pixel buffer popped while empty");

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    initial
    begin : pixel_checker
        forever
        begin
            wait (mon.pix_count > checked_count);
            check_pixel(checked_count);
            checked_count++;
        end
    end

    initial
    begin : watchdog
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout after %0d clock cycles, pixel stream did not reach its end",
                 WATCH_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin : main_sequence
        void'($urandom(32'h467410db));
        reset             = 1'b1;
        en                = 1'b1;
        word_for_frame[0] = random_word();
        word_for_frame[1] = random_word();
        word_for_frame[2] = word_for_frame[1];
        data              = word_for_frame[0];
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_reset_state();
        finish_test(T_RESET);
        check_init_sequence();
        finish_test(T_INIT);
        wait (mon.pix_count >= CHANGE_IDX);
        @(negedge clk);
        data = word_for_frame[1];   // decoder is a few pixels ahead, frame 1 takes it
        wait (checked_count >= FRAME_PIXELS);
        finish_test(T_CONTENT);
        run_stall();
        wait (checked_count >= 2 * FRAME_PIXELS);
        finish_test(T_SAMPLING);
        wait (checked_count >= END_IDX);   // frame 2 text shows no raster shift
        finish_test(T_STALL);
        check_protocol_end();
        finish_test(T_PROTO);
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- dv/spi_oled_monitor.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module spi_oled_monitor
    import pixel_pkg::*;
    import oled_cmd_pkg::*;
(
    input logic oled_csn,
    input logic oled_clk,
    input logic oled_mosi,
    input logic oled_dc
);

    localparam int FRAME_PIXELS = `OLED_WIDTH * `OLED_HEIGHT;
    localparam int LOG_DEPTH    = 4 * FRAME_PIXELS;

    event      byte_done;
    event      pixel_done;

    cmd_byte_t cmd_log [16];
    color_t    pix_log [LOG_DEPTH];   // every pixel seen, in arrival order
    int        cmd_count        = 0;
    int        pix_count        = 0;
    int        clk_edges        = 0;
    int        frame_errors     = 0;   // csn rose in the middle of a byte
    logic      data_before_init = 1'b0;
    logic      hi_valid         = 1'b0;   // high byte waiting for its partner

    cmd_byte_t shreg = '0;
    cmd_byte_t hi_byte;
    int        bit_n = 0;

    task automatic log_command(input cmd_byte_t b);
        if (cmd_count < 16)
        begin
            cmd_log[cmd_count] = b;
        end
        cmd_count = cmd_count + 1;
    endtask

    task automatic log_data(input cmd_byte_t b);
        if (cmd_count < INIT_LEN)
        begin
            data_before_init = 1'b1;
        end
        if (!hi_valid)
        begin
            hi_byte  = b;
            hi_valid = 1'b1;
        end
        else
        begin
            hi_valid = 1'b0;
            if (pix_count < LOG_DEPTH)
            begin
                pix_log[pix_count] = {hi_byte, b};
            end
            pix_count = pix_count + 1;   // count moves last, the log is already filled
            -> pixel_done;
        end
    endtask

    // panel samples mosi on the rising SPI clock
    always @(posedge oled_clk)
    begin
        clk_edges = clk_edges + 1;
        if (!oled_csn)
        begin
            shreg = {shreg[6:0], oled_mosi};   // MSB first
            bit_n = bit_n + 1;
            if (bit_n == 8)
            begin
                bit_n = 0;
                if (!oled_dc)
                begin
                    log_command(shreg);
                end
                else
                begin
                    log_data(shreg);
                end
                -> byte_done;
            end
        end
    end

    always @(posedge oled_csn)
    begin
        if (bit_n != 0)
        begin
            frame_errors = frame_errors + 1;
        end
        bit_n = 0;
    end

endmodule

//--- hex_decoder/hex_decoder.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module hex_decoder
    import pixel_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  logic [`HEX_DATA_BITS-1:0] data,
    input  logic                      credit,
    output logic                      push,
    output color_t                    pixel
);

    localparam int CREDIT_W = $clog2(`PIXEL_FIFO_DEPTH + 1);

    pixel_x_t                  x;
    pixel_y_t                  y;
    logic [`HEX_DATA_BITS-1:0] frame_word;   // word sampled at pixel (0,0)
    logic [CREDIT_W-1:0]       credits;

    logic                      issue;
    logic                      frame_start;
    logic [`HEX_DATA_BITS-1:0] word_now;
    logic [3:0]                tcol;
    logic [2:0]                trow;
    logic [2:0]                gx;
    logic [2:0]                gy;
    logic [4:0]                digit;
    nibble_t                   nib;
    glyph_row_t                grow;
    logic                      lit;
    color_t                    color_next;

    assign issue       = en && (credits != '0);
    assign frame_start = (x == '0) && (y == '0);
    assign word_now    = frame_start ? data : frame_word;   // new word shows from pixel 0

    always_comb
    begin
        tcol  = 4'(x / `GLYPH_W);
        trow  = 3'(y / `GLYPH_H);
        gx    = 3'(x % `GLYPH_W);
        gy    = 3'(y % `GLYPH_H);
        digit = {trow[0], tcol};   // 16 digits per text row
        nib   = word_now[`HEX_DATA_BITS - 1 - 4 * digit -: 4];   // digit 0 is the top nibble
        grow  = hex_glyph_row(nib, gy);
        lit   = (trow < 3'd2) && grow[5 - gx];
        color_next = lit ? `FG_COLOR : `BG_COLOR;
    end

    // raster walk, one step per issued pixel
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x <= '0;
            y <= '0;
        end
        else if (issue)
        begin
            if (x == pixel_x_t'(`OLED_WIDTH - 1))
            begin
                x <= '0;
                y <= (y == pixel_y_t'(`OLED_HEIGHT - 1)) ? '0 : y + 1'b1;
            end
            else
            begin
                x <= x + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue && frame_start)
        begin
            frame_word <= data;
        end
    end

    // one credit per buffer entry
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits <= CREDIT_W'(`PIXEL_FIFO_DEPTH);
        end
        else
        begin
            case ({issue, credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // both or neither
            endcase
        end
    end

    // colour registered, push one cycle after the decision
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            push <= 1'b0;
        end
        else
        begin
            push <= issue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            pixel <= color_next;
        end
    end

    // buffer must never hand back more credits than it has entries
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(`PIXEL_FIFO_DEPTH))
        else $error("hex_decoder credit count above buffer depth");

    a_push_with_credit: assert property (@(posedge clk) disable iff (reset)
        push |-> $past(credits) != '0)
        else $error("hex_decoder pushed without a credit");

endmodule

//--- logic/hex_oled_top.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module hex_oled_top
    import pixel_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`HEX_DATA_BITS-1:0] data,
    input  logic                      en,
    output logic                      oled_csn,
    output logic                      oled_clk,
    output logic                      oled_mosi,
    output logic                      oled_dc,
    output logic                      oled_resn
);

    logic   push;
    color_t pixel;
    logic   credit;
    color_t pix_out;
    logic   pix_avail;
    logic   pop;

    hex_decoder hex_decoder_inst
    (
        .clk    (clk),
        .reset  (reset),
        .en     (en),
        .data   (data),
        .credit (credit),
        .push   (push),
        .pixel  (pixel)
    );

    pixel_fifo pixel_fifo_inst
    (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .pixel     (pixel),
        .pop       (pop),
        .pix_out   (pix_out),
        .pix_avail (pix_avail),
        .credit    (credit)
    );

    oled_video oled_video_inst
    (
        .clk       (clk),
        .reset     (reset),
        .pix_out   (pix_out),
        .pix_avail (pix_avail),
        .pop       (pop),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

endmodule

//--- logic/pixel_fifo.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module pixel_fifo
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  color_t pixel,
    input  logic   pop,
    output color_t pix_out,
    output logic   pix_avail,
    output logic   credit
);

    localparam int PTR_W = $clog2(`PIXEL_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`PIXEL_FIFO_DEPTH + 1);

    color_t           mem [`PIXEL_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign pix_out   = mem[rd_ptr];   // head entry
    assign pix_avail = (count != '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= pixel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(`PIXEL_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(`PIXEL_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop;   // freed entry goes back to the decoder
        end
    end

    // the credit loop should make both of these impossible
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> count != CNT_W'(`PIXEL_FIFO_DEPTH))
        else $error("pixel_fifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0)
        else $error("pixel_fifo pop while empty");

endmodule

//--- oled_video/oled_video.sv
`timescale 1ns/1ps
`include "oled_params.svh"

module oled_video
    import pixel_pkg::*;
    import oled_cmd_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  color_t pix_out,
    input  logic   pix_avail,
    output logic   pop,
    output logic   oled_csn,
    output logic   oled_clk,
    output logic   oled_mosi,
    output logic   oled_dc,
    output logic   oled_resn
);

    localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES);

    oled_state_t       state;
    logic [HOLD_W-1:0] hold_cnt;
    logic [3:0]        init_idx;
    logic              lo_pending;   // low byte of current pixel still to send
    cmd_byte_t         lo_byte;

    logic              busy;
    logic [6:0]        sh;   // bits still to shift, next one at bit 6
    logic [2:0]        bit_cnt;

    logic              start;
    cmd_byte_t         start_byte;
    logic              start_dc;

    assign busy = !oled_csn;

    // byte source for the shifter
    always_comb
    begin
        start      = 1'b0;
        start_byte = '0;
        start_dc   = 1'b0;
        pop        = 1'b0;
        if (!busy)
        begin
            case (state)
                ST_INIT:
                begin
                    start      = 1'b1;
                    start_byte = init_byte(init_idx);
                end
                ST_PIXELS:
                begin
                    if (lo_pending)
                    begin
                        start      = 1'b1;
                        start_byte = lo_byte;
                        start_dc   = 1'b1;
                    end
                    else if (pix_avail)
                    begin
                        pop        = 1'b1;
                        start      = 1'b1;
                        start_byte = pix_out[15:8];   // MSB first
                        start_dc   = 1'b1;
                    end
                end
                default:
                begin
                    start = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_RESET;
            hold_cnt   <= '0;
            oled_resn  <= 1'b0;
            init_idx   <= '0;
            lo_pending <= 1'b0;
        end
        else
        begin
            case (state)
                ST_RESET:
                begin
                    if (hold_cnt == HOLD_W'(`RESET_HOLD_CYCLES - 1))
                    begin
                        oled_resn <= 1'b1;
                        state     <= ST_INIT;
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                ST_INIT:
                begin
                    if (start)
                    begin
                        init_idx <= init_idx + 1'b1;
                        if (init_idx == 4'(INIT_LEN - 1))
                        begin
                            state <= ST_PIXELS;
                        end
                    end
                end
                default:
                begin
                    if (pop)
                    begin
                        lo_pending <= 1'b1;
                    end
                    else if (start)
                    begin
                        lo_pending <= 1'b0;   // low byte went out
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            lo_byte <= pix_out[7:0];
        end
    end

    // byte shifter, SPI clock at clk/2, 16 cycles with csn low per byte
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            oled_csn  <= 1'b1;
            oled_clk  <= 1'b0;
            oled_mosi <= 1'b0;
            oled_dc   <= 1'b0;
            bit_cnt   <= '0;
        end
        else if (start)
        begin
            oled_csn  <= 1'b0;
            oled_clk  <= 1'b0;
            oled_dc   <= start_dc;
            oled_mosi <= start_byte[7];
            bit_cnt   <= '0;
        end
        else if (busy)
        begin
            if (!oled_clk)
            begin
                oled_clk <= 1'b1;   // panel samples here
            end
            else
            begin
                oled_clk <= 1'b0;
                if (bit_cnt == 3'd7)
                begin
                    oled_csn <= 1'b1;   // byte done
                end
                else
                begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    oled_mosi <= sh[6];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            sh <= start_byte[6:0];
        end
        else if (busy && oled_clk)
        begin
            sh <= {sh[5:0], 1'b0};
        end
    end

    // command/data flag must hold for the whole byte
    a_dc_stable: assert property (@(posedge clk) disable iff (reset)
        (!oled_csn && !$past(oled_csn)) |-> $stable(oled_dc))
        else $error("oled_dc changed during a byte");

endmodule

//--- src.f
+incdir+common
common/pixel_pkg.sv
common/oled_cmd_pkg.sv
hex_decoder/hex_decoder.sv
logic/pixel_fifo.sv
oled_video/oled_video.sv
logic/hex_oled_top.sv
dv/spi_oled_monitor.sv
dv/hex_oled_tb.sv
